//--- rtl/matmul_params.svh
`ifndef MATMUL_PARAMS_SVH
`define MATMUL_PARAMS_SVH

// Mesh dimension and element width
`define MAT_SIZE 4
`define ELEM_WIDTH 8

// Memory interface
`define ADDR_WIDTH 10
`define STRIDE_WIDTH 8
`define MEM_LATENCY 1

// Pipeline depth of the multiply-accumulate inside each PE
`define MAC_STAGES 3

// PE33 holds its final sum once the last skewed operand pair has crossed
// the mesh and gone through the MAC pipeline
`define CAPTURE_CYCLE (3 * `MAT_SIZE - 1 + `MAC_STAGES)

// The drain emits one column per cycle after capture, done marks the last one
`define DONE_CYCLE (`CAPTURE_CYCLE + `MAT_SIZE)

`define CYCLE_WIDTH 8

`endif

//--- rtl/matmul_pkg.sv
`include "matmul_params.svh"

package matmul_pkg;

    // One matrix element, arithmetic wraps modulo 2**ELEM_WIDTH
    typedef logic [`ELEM_WIDTH-1:0] elem_t;

    // One memory word or one column of C, element 0 sits in the low bits
    typedef elem_t [`MAT_SIZE-1:0] vector_t;

    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    typedef logic [`STRIDE_WIDTH-1:0] stride_t;

    // Controller cycle count, wide enough for DONE_CYCLE
    typedef logic [`CYCLE_WIDTH-1:0] cycle_t;

endpackage

//--- rtl/matmul_controller.sv
`timescale 1ns/1ns
`include "matmul_params.svh"

module matmul_controller
(
    input  logic               clk,
    input  logic               reset,
    input  logic               start_mat_mul,
    output matmul_pkg::cycle_t cycle_count,
    output logic               capture,
    output logic               done_mat_mul
);

    //////////////////////////////
    // Cycle counter
    //////////////////////////////

    // Count is zero in the first cycle that start is seen high
    // It holds at its maximum so a host that never drops start sees one done
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            cycle_count <= '0;
        end
        else if (cycle_count != '1)
        begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    //////////////////////////////
    // Capture strobe and done
    //////////////////////////////

    // The drain latches the whole mesh in this cycle
    assign capture = (cycle_count == matmul_pkg::cycle_t'(`CAPTURE_CYCLE));

    // Registered one cycle early so done is high exactly in DONE_CYCLE
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            done_mat_mul <= 1'b0;
        end
        else
        begin
            done_mat_mul <= (cycle_count == matmul_pkg::cycle_t'(`DONE_CYCLE - 1));
        end
    end

endmodule

//--- rtl/operand_feeder.sv
`timescale 1ns/1ns
`include "matmul_params.svh"

module operand_feeder
(
    input  logic                clk,
    input  logic                reset,
    input  logic                start_mat_mul,
    input  matmul_pkg::cycle_t  cycle_count,
    input  matmul_pkg::addr_t   address_mat_a,
    input  matmul_pkg::addr_t   address_mat_b,
    input  matmul_pkg::stride_t address_stride_a,
    input  matmul_pkg::stride_t address_stride_b,
    input  matmul_pkg::vector_t a_data,
    input  matmul_pkg::vector_t b_data,
    output matmul_pkg::addr_t   a_addr,
    output matmul_pkg::addr_t   b_addr,
    output logic                a_mem_access,
    output logic                b_mem_access,
    output matmul_pkg::vector_t a_skewed,
    output matmul_pkg::vector_t b_skewed
);

    // Index 0 is operand A, index 1 is operand B
    matmul_pkg::addr_t   base [2];
    matmul_pkg::stride_t stride [2];
    matmul_pkg::vector_t rdata [2];
    matmul_pkg::addr_t   addr_q [2];
    logic                access_q [2];
    matmul_pkg::cycle_t  access_cnt [2];
    matmul_pkg::vector_t masked [2];
    matmul_pkg::vector_t skewed [2];

    assign base[0]   = address_mat_a;
    assign base[1]   = address_mat_b;
    assign stride[0] = address_stride_a;
    assign stride[1] = address_stride_b;
    assign rdata[0]  = a_data;
    assign rdata[1]  = b_data;

    assign a_addr       = addr_q[0];
    assign b_addr       = addr_q[1];
    assign a_mem_access = access_q[0];
    assign b_mem_access = access_q[1];
    assign a_skewed     = skewed[0];
    assign b_skewed     = skewed[1];

    for (genvar op = 0; op < 2; op++)
    begin : g_operand
        logic data_valid;

        //////////////////////////////
        // Address generation
        //////////////////////////////

        // One word per cycle in cycles 1..MAT_SIZE, addresses wrap at ADDR_WIDTH
        always_ff @(posedge clk)
        begin
            if (reset || !start_mat_mul ||
                cycle_count >= matmul_pkg::cycle_t'(`MAT_SIZE))
            begin
                addr_q[op]   <= base[op] - matmul_pkg::addr_t'(stride[op]);
                access_q[op] <= 1'b0;
            end
            else
            begin
                addr_q[op]   <= addr_q[op] + matmul_pkg::addr_t'(stride[op]);
                access_q[op] <= 1'b1;
            end
        end

        //////////////////////////////
        // Read data valid
        //////////////////////////////

        // Counts access cycles so the memory latency window is hidden
        always_ff @(posedge clk)
        begin
            if (reset || !start_mat_mul || !access_q[op])
            begin
                access_cnt[op] <= '0;
            end
            else
            begin
                access_cnt[op] <= access_cnt[op] + 1'b1;
            end
        end

        assign data_valid = (access_cnt[op] >= matmul_pkg::cycle_t'(`MEM_LATENCY));
        assign masked[op] = data_valid ? rdata[op] : '0;

        //////////////////////////////
        // Triangular skew
        //////////////////////////////

        // Element 0 enters the mesh with no delay
        assign skewed[op][0] = masked[op][0];

        // Element i goes through a line of i registers
        for (genvar i = 1; i < `MAT_SIZE; i++)
        begin : g_skew
            matmul_pkg::elem_t dly [i];

            always_ff @(posedge clk)
            begin
                if (reset || !start_mat_mul || cycle_count == '0)
                begin
                    dly <= '{default: '0};
                end
                else
                begin
                    dly[0] <= masked[op][i];
                    for (int d = 1; d < i; d++)
                    begin
                        dly[d] <= dly[d-1];
                    end
                end
            end

            assign skewed[op][i] = dly[i-1];
        end
    end

endmodule

//--- rtl/processing_element.sv
`timescale 1ns/1ns

module processing_element
(
    input  logic              clk,
    input  logic              reset,
    input  logic              start_mat_mul,
    input  matmul_pkg::elem_t in_a,
    input  matmul_pkg::elem_t in_b,
    output matmul_pkg::elem_t out_a,
    output matmul_pkg::elem_t out_b,
    output matmul_pkg::elem_t result
);

    matmul_pkg::elem_t mac_a;
    matmul_pkg::elem_t mac_b;
    matmul_pkg::elem_t product;

    // Operands move one PE right (A) and one PE down (B) per cycle
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            out_a <= '0;
            out_b <= '0;
        end
        else
        begin
            out_a <= in_a;
            out_b <= in_b;
        end
    end

    //////////////////////////////
    // Three stage MAC
    //////////////////////////////

    // Operand register, product register, then the accumulator
    // The product keeps only the low ELEM_WIDTH bits, so the sum wraps
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            mac_a   <= '0;
            mac_b   <= '0;
            product <= '0;
            result  <= '0;
        end
        else
        begin
            mac_a   <= in_a;
            mac_b   <= in_b;
            product <= mac_a * mac_b;
            result  <= result + product;
        end
    end

endmodule

//--- rtl/result_drain.sv
`timescale 1ns/1ns
`include "matmul_params.svh"

module result_drain
(
    input  logic                clk,
    input  logic                reset,
    input  logic                start_mat_mul,
    input  logic                capture,
    input  matmul_pkg::addr_t   address_mat_c,
    input  matmul_pkg::stride_t address_stride_c,
    input  matmul_pkg::elem_t   results [`MAT_SIZE][`MAT_SIZE],
    output matmul_pkg::vector_t c_data_out,
    output matmul_pkg::addr_t   c_addr,
    output logic                c_data_available
);

    // Column j of C waits in col_q[j], col_q[0] is on the output
    matmul_pkg::vector_t col_q [`MAT_SIZE];
    matmul_pkg::cycle_t  cols_left;

    assign c_data_out = col_q[0];

    //////////////////////////////
    // Capture and shift out
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            col_q            <= '{default: '0};
            cols_left        <= '0;
            c_data_available <= 1'b0;
            c_addr           <= address_mat_c - matmul_pkg::addr_t'(address_stride_c);
        end
        else if (capture)
        begin
            // Row i of the mesh becomes element i of each column word
            for (int j = 0; j < `MAT_SIZE; j++)
            begin
                for (int i = 0; i < `MAT_SIZE; i++)
                begin
                    col_q[j][i] <= results[i][j];
                end
            end
            cols_left        <= matmul_pkg::cycle_t'(`MAT_SIZE - 1);
            c_data_available <= 1'b1;
            c_addr           <= c_addr + matmul_pkg::addr_t'(address_stride_c);
        end
        else if (c_data_available)
        begin
            // Zeros fill in behind, so the output is clear after the last column
            for (int j = 0; j < `MAT_SIZE - 1; j++)
            begin
                col_q[j] <= col_q[j+1];
            end
            col_q[`MAT_SIZE-1] <= '0;

            if (cols_left == '0)
            begin
                c_data_available <= 1'b0;
            end
            else
            begin
                cols_left <= cols_left - 1'b1;
                c_addr    <= c_addr + matmul_pkg::addr_t'(address_stride_c);
            end
        end
    end

endmodule

//--- rtl/systolic_matmul_top.sv
`timescale 1ns/1ns
`include "matmul_params.svh"

module systolic_matmul_top
(
    input  logic                clk,
    input  logic                reset,
    input  logic                start_mat_mul,
    input  matmul_pkg::addr_t   address_mat_a,
    input  matmul_pkg::addr_t   address_mat_b,
    input  matmul_pkg::addr_t   address_mat_c,
    input  matmul_pkg::stride_t address_stride_a,
    input  matmul_pkg::stride_t address_stride_b,
    input  matmul_pkg::stride_t address_stride_c,
    input  matmul_pkg::vector_t a_data,
    input  matmul_pkg::vector_t b_data,
    output logic                done_mat_mul,
    output logic                a_mem_access,
    output logic                b_mem_access,
    output logic                c_data_available,
    output matmul_pkg::addr_t   a_addr,
    output matmul_pkg::addr_t   b_addr,
    output matmul_pkg::addr_t   c_addr,
    output matmul_pkg::vector_t c_data_out
);

    matmul_pkg::cycle_t  cycle_count;
    logic                capture;
    matmul_pkg::vector_t a_skewed;
    matmul_pkg::vector_t b_skewed;

    // A travels along rows, B down columns, the extra slot holds the edge output
    matmul_pkg::elem_t a_link [`MAT_SIZE][`MAT_SIZE+1];
    matmul_pkg::elem_t b_link [`MAT_SIZE+1][`MAT_SIZE];
    matmul_pkg::elem_t results [`MAT_SIZE][`MAT_SIZE];

    matmul_controller u_controller
    (
        .clk           (clk),
        .reset         (reset),
        .start_mat_mul (start_mat_mul),
        .cycle_count   (cycle_count),
        .capture       (capture),
        .done_mat_mul  (done_mat_mul)
    );

    operand_feeder u_feeder
    (
        .clk              (clk),
        .reset            (reset),
        .start_mat_mul    (start_mat_mul),
        .cycle_count      (cycle_count),
        .address_mat_a    (address_mat_a),
        .address_mat_b    (address_mat_b),
        .address_stride_a (address_stride_a),
        .address_stride_b (address_stride_b),
        .a_data           (a_data),
        .b_data           (b_data),
        .a_addr           (a_addr),
        .b_addr           (b_addr),
        .a_mem_access     (a_mem_access),
        .b_mem_access     (b_mem_access),
        .a_skewed         (a_skewed),
        .b_skewed         (b_skewed)
    );

    //////////////////////////////
    // PE mesh
    //////////////////////////////

    for (genvar i = 0; i < `MAT_SIZE; i++)
    begin : g_row
        // Skewed A element i feeds the left edge of row i
        assign a_link[i][0] = a_skewed[i];
        // Skewed B element i feeds the top edge of column i
        assign b_link[0][i] = b_skewed[i];

        for (genvar j = 0; j < `MAT_SIZE; j++)
        begin : g_col
            processing_element u_pe
            (
                .clk           (clk),
                .reset         (reset),
                .start_mat_mul (start_mat_mul),
                .in_a          (a_link[i][j]),
                .in_b          (b_link[i][j]),
                .out_a         (a_link[i][j+1]),
                .out_b         (b_link[i+1][j]),
                .result        (results[i][j])
            );
        end
    end

    result_drain u_drain
    (
        .clk              (clk),
        .reset            (reset),
        .start_mat_mul    (start_mat_mul),
        .capture          (capture),
        .address_mat_c    (address_mat_c),
        .address_stride_c (address_stride_c),
        .results          (results),
        .c_data_out       (c_data_out),
        .c_addr           (c_addr),
        .c_data_available (c_data_available)
    );

endmodule

//--- tb/systolic_matmul_assertions.sv
`timescale 1ns/1ns

module systolic_matmul_assertions
(
    input logic clk,
    input logic reset,
    input logic start_mat_mul,
    input logic a_mem_access,
    input logic b_mem_access,
    input logic c_data_available,
    input logic done_mat_mul
);

    // Failed assertions so far, polled by the testbench
    int unsigned failures = 0;

    // Four columns back to back, then the output goes quiet
    avail_four_cycles : assert property (@(posedge clk) disable iff (reset)
        $rose(c_data_available) |=> c_data_available ##1 c_data_available
            ##1 c_data_available ##1 !c_data_available)
    else
    begin
        $error("c_data_available was not high for exactly four cycles");
        failures++;
    end

    // Done lands on the fourth column and lasts a single cycle
    done_on_last_column : assert property (@(posedge clk) disable iff (reset)
        done_mat_mul |-> (c_data_available && $past(c_data_available, 3) &&
            !$past(c_data_available, 4)) ##1 !done_mat_mul)
    else
    begin
        $error("done_mat_mul is not a single pulse on the fourth column");
        failures++;
    end

    no_access_without_start : assert property (@(posedge clk) disable iff (reset)
        !start_mat_mul |-> !a_mem_access && !b_mem_access)
    else
    begin
        $error("A memory access flag is high while start_mat_mul is low");
        failures++;
    end

endmodule

//--- tb/tb_systolic_matmul.sv
`timescale 1ns/1ns
`include "matmul_params.svh"

module tb_systolic_matmul;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_RUNS = 20;
    localparam int CYCLES_PER_RUN = 30;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic                clk = 1'b0;
    logic                reset;
    logic                start_mat_mul;
    matmul_pkg::addr_t   address_mat_a;
    matmul_pkg::addr_t   address_mat_b;
    matmul_pkg::addr_t   address_mat_c;
    matmul_pkg::stride_t address_stride_a;
    matmul_pkg::stride_t address_stride_b;
    matmul_pkg::stride_t address_stride_c;
    matmul_pkg::vector_t a_data;
    matmul_pkg::vector_t b_data;
    logic                done_mat_mul;
    logic                a_mem_access;
    logic                b_mem_access;
    logic                c_data_available;
    matmul_pkg::addr_t   a_addr;
    matmul_pkg::addr_t   b_addr;
    matmul_pkg::addr_t   c_addr;
    matmul_pkg::vector_t c_data_out;

    logic [31:0]         lfsr = 32'hfeb5af66;
    matmul_pkg::vector_t mem_a [1 << `ADDR_WIDTH];
    matmul_pkg::vector_t mem_b [1 << `ADDR_WIDTH];
    matmul_pkg::addr_t   a_addr_seen;
    matmul_pkg::addr_t   b_addr_seen;
    matmul_pkg::vector_t expected_c [`MAT_SIZE];

    systolic_matmul_top DUT (.*);

    bind systolic_matmul_top systolic_matmul_assertions u_assertions (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Both memories answer one cycle after the address is presented
    always @(negedge clk)
    begin
        a_data      <= mem_a[a_addr_seen];
        b_data      <= mem_b[b_addr_seen];
        a_addr_seen <= a_addr;
        b_addr_seen <= b_addr;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;

        value = '0;
        for (int n = 0; n < count; n++)
        begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return value;
    endfunction

    function automatic matmul_pkg::addr_t word_address(input matmul_pkg::addr_t base,
                                                       input matmul_pkg::stride_t stride,
                                                       input int index);
        return base + matmul_pkg::addr_t'(index) * matmul_pkg::addr_t'(stride);
    endfunction

    // Word k of A is column k and word k of B is row k, every sum wraps at 8 bits
    function automatic void compute_expected();
        matmul_pkg::elem_t sum;
        matmul_pkg::elem_t product;

        for (int j = 0; j < `MAT_SIZE; j++)
        begin
            for (int i = 0; i < `MAT_SIZE; i++)
            begin
                sum = '0;
                for (int k = 0; k < `MAT_SIZE; k++)
                begin
                    product = mem_a[word_address(address_mat_a, address_stride_a, k)][i]
                            * mem_b[word_address(address_mat_b, address_stride_b, k)][j];
                    sum = sum + product;
                end
                expected_c[j][i] = sum;
            end
        end
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_idle();
        assert (!done_mat_mul && !a_mem_access && !b_mem_access && !c_data_available)
        else report_failure($sformatf(
            "Error: {done_mat_mul, a_mem_access, b_mem_access, c_data_available} is 0x%h",
            {done_mat_mul, a_mem_access, b_mem_access, c_data_available}));
    endtask

    task automatic run_multiply(input int run);
        int                cycle;
        int                a_reads;
        int                b_reads;
        int                column;
        matmul_pkg::addr_t want;

        // Start stays low for one cycle while new bases and strides settle
        @(negedge clk);
        start_mat_mul    = 1'b0;
        address_mat_a    = matmul_pkg::addr_t'(random_bits(`ADDR_WIDTH));
        address_mat_b    = matmul_pkg::addr_t'(random_bits(`ADDR_WIDTH));
        address_mat_c    = matmul_pkg::addr_t'(random_bits(`ADDR_WIDTH));
        address_stride_a = matmul_pkg::stride_t'(random_bits(`STRIDE_WIDTH));
        address_stride_b = matmul_pkg::stride_t'(random_bits(`STRIDE_WIDTH));
        address_stride_c = matmul_pkg::stride_t'(random_bits(`STRIDE_WIDTH));
        // Every fourth run starts near the top of memory so the addresses wrap
        if (run % 4 == 1)
        begin
            address_mat_a = address_mat_a | 10'h3f0;
            address_mat_b = address_mat_b | 10'h3f0;
            address_mat_c = address_mat_c | 10'h3f0;
        end
        compute_expected();
        @(negedge clk);
        check_idle();
        start_mat_mul = 1'b1;
        cycle   = 0;
        a_reads = 0;
        b_reads = 0;
        column  = 0;

        // Cycle 0 is the one in which start rises
        do
        begin
            @(negedge clk);
            cycle++;
            assert (cycle <= 2 * `DONE_CYCLE)
            else report_failure("done_mat_mul did not arrive in time");
            if (a_mem_access)
            begin
                want = word_address(address_mat_a, address_stride_a, a_reads);
                assert (a_addr == want)
                else report_failure($sformatf("Error: a_addr is 0x%h, expected 0x%h",
                                              a_addr, want));
                a_reads++;
            end
            if (b_mem_access)
            begin
                want = word_address(address_mat_b, address_stride_b, b_reads);
                assert (b_addr == want)
                else report_failure($sformatf("Error: b_addr is 0x%h, expected 0x%h",
                                              b_addr, want));
                b_reads++;
            end
            if (c_data_available)
            begin
                assert (column < `MAT_SIZE)
                else report_failure("c_data_available stayed high past the last column");
                want = word_address(address_mat_c, address_stride_c, column);
                assert (c_data_out == expected_c[column])
                else report_failure($sformatf("Error: c_data_out is 0x%h, expected 0x%h",
                                              c_data_out, expected_c[column]));
                assert (c_addr == want)
                else report_failure($sformatf("Error: c_addr is 0x%h, expected 0x%h",
                                              c_addr, want));
                column++;
            end
        end
        while (!done_mat_mul);

        assert (cycle == `DONE_CYCLE && column == `MAT_SIZE)
        else report_failure($sformatf("done_mat_mul came in cycle %0d after %0d columns",
                                      cycle, column));
        assert (a_reads == `MAT_SIZE && b_reads == `MAT_SIZE)
        else report_failure("The memories were not read in exactly four cycles each");
        // Start is still high here, yet the outputs must already be quiet
        @(negedge clk);
        check_idle();
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial
    begin
        reset            = 1'b1;
        start_mat_mul    = 1'b0;
        address_mat_a    = '0;
        address_mat_b    = '0;
        address_mat_c    = '0;
        address_stride_a = '0;
        address_stride_b = '0;
        address_stride_c = '0;
        a_data           = '0;
        b_data           = '0;
        a_addr_seen      = '0;
        b_addr_seen      = '0;
        for (int w = 0; w < (1 << `ADDR_WIDTH); w++)
        begin
            mem_a[w] = random_bits(32);
            mem_b[w] = random_bits(32);
        end
        repeat (RESET_CYCLES)
        begin
            @(negedge clk);
            check_idle();
        end
        reset = 1'b0;
        for (int run = 0; run < NUM_RUNS; run++)
            run_multiply(run);
        repeat (2) @(negedge clk);
        if (DUT.u_assertions.failures == 0)
        begin
            $display("Test completed successfully");
            $finish;
        end
        else
            report_failure("A protocol assertion failed");
    end

    always @(negedge clk)
    begin
        assert (DUT.u_assertions.failures == 0)
        else report_failure("A protocol assertion failed");
    end

    // Each multiply needs well under 30 cycles including its setup
    initial
    begin
        #((RESET_CYCLES + NUM_RUNS * CYCLES_PER_RUN) * CLK_PERIOD);
        report_failure("Timeout, the multiplies did not finish in time");
    end

endmodule

//--- sources.f
+incdir+rtl
rtl/matmul_pkg.sv
rtl/matmul_controller.sv
rtl/operand_feeder.sv
rtl/processing_element.sv
rtl/result_drain.sv
rtl/systolic_matmul_top.sv
tb/systolic_matmul_assertions.sv
tb/tb_systolic_matmul.sv
